// ==== logic/digitSplitter.sv ====
`timescale 1ns/100ps
`default_nettype none

// Value to four digit codes by double-dabble, fixed latency in both modes
module digitSplitter (
	input logic CLKDV,
	input logic reset,
	input logic valueStrobe,
	input numPkg::valueT value,
	input numPkg::modeT mode,
	digitBus.src out
);
	import numPkg::*;
	import dispPkg::*;

	valueT shiftReg;                        // Binary bits still to shift in
	digitsT bcdReg;                         // Digit accumulator
	modeT modeReg;
	logic overReg;                          // Decimal value beyond four digits
	logic [convCntWidth-1:0] stepCnt;       // Shift steps left
	logic busy;
	digitsT stepIn;                         // Accumulator before the shift
	maskT blankNext;

	// Add three to every digit of five or more
	function automatic digitsT dabble(input digitsT d);
		digitsT r;
		r = d;
		for (int i = 0; i < numDigits; i++)
		begin
			if (r[i] >= 4'd5)
				r[i] = r[i] + 4'd3;
		end
		return r;
	endfunction

	// Hex mode skips the correction and so just moves the nibbles across
	assign stepIn = (modeReg == modeDec) ? dabble(bcdReg) : bcdReg;

	// Leading zeros above digit 0, decimal only
	always_comb
	begin
		blankNext = maskNone;
		if (modeReg == modeDec)
		begin
			blankNext[3] = (bcdReg[3] == 4'd0);
			blankNext[2] = blankNext[3] && (bcdReg[2] == 4'd0);
			blankNext[1] = blankNext[2] && (bcdReg[1] == 4'd0);
		end
	end

	// Control
	always_ff @(posedge CLKDV or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			stepCnt <= '0;
			out.load <= 1'b0;
		end
		else
		begin
			out.load <= 1'b0;
			if (valueStrobe)
			begin
				busy <= 1'b1;               // A new value restarts any conversion
				stepCnt <= convCntWidth'(convCycles);
			end
			else if (busy)
			begin
				if (stepCnt != '0)
					stepCnt <= stepCnt - 1'b1;
				else
				begin
					busy <= 1'b0;
					out.load <= 1'b1;       // 17 edges after the strobe
				end
			end
		end
	end

	// Datapath
	always_ff @(posedge CLKDV)
	begin
		if (valueStrobe)
		begin
			shiftReg <= value;
			bcdReg <= '0;
			modeReg <= mode;
			overReg <= (mode == modeDec) && (value > valueT'(decLimit));
		end
		else if (busy && stepCnt != '0)
			{bcdReg, shiftReg} <= {stepIn, shiftReg} << 1;

		// Result goes out with the load pulse
		if (busy && stepCnt == '0)
		begin
			out.digits <= bcdReg;
			out.blankMask <= overReg ? maskNone : blankNext;
			out.dashMask <= overReg ? maskAll : maskNone;
		end
	end

endmodule : digitSplitter

`default_nettype wire

// ==== logic/dispPkg.sv ====
`default_nettype none

// Display geometry and segment encodings
package dispPkg;

	// Four common-anode digits
	localparam int numDigits = 4;
	localparam int digitIdxWidth = $clog2(numDigits);

	// Cycles each digit stays lit
	localparam int dwellCycles = 4;
	localparam int dwellWidth = $clog2(dwellCycles);

	// Segments g down to a, low lights the segment
	typedef logic [6:0] segT;

	// One bit per digit, low selects the digit
	typedef logic [numDigits-1:0] anodeT;

	// Per-digit flags, bit n belongs to digit n
	typedef logic [numDigits-1:0] maskT;

	// All segments dark
	localparam segT segBlank = 7'b1111111;

	// Middle bar only
	localparam segT segDash = 7'b0111111;  // g low, a to f high

	// Nothing selected
	localparam anodeT anodesOff = '1;

	// Blank and dash masks with every digit flagged
	localparam maskT maskAll = '1;
	localparam maskT maskNone = '0;

endpackage : dispPkg

`default_nettype wire

// ==== logic/displayBuses.sv ====
`timescale 1ns/100ps
`default_nettype none

// Converter to frame buffer, one frame per load pulse
interface digitBus;
	import numPkg::*;
	import dispPkg::*;

	logic load;                             // Single-cycle, no back-pressure
	digitsT digits;                         // Valid with load
	maskT blankMask;                        // Digit dark
	maskT dashMask;                         // Digit shows a dash, wins over blank

	modport src (output load, output digits, output blankMask, output dashMask);
	modport dst (input load, input digits, input blankMask, input dashMask);

endinterface : digitBus

// Frame buffer to scanner
interface frameBus;
	import numPkg::*;
	import dispPkg::*;

	logic frameStart;                       // From the scanner, last cycle of digit 0
	digitsT digits;                         // Displayed frame
	maskT blankMask;
	maskT dashMask;

	// Buffer side
	modport src (input frameStart, output digits, output blankMask, output dashMask);

	// Scanner side
	modport dst (output frameStart, input digits, input blankMask, input dashMask);

endinterface : frameBus

`default_nettype wire

// ==== logic/frameBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Pending and displayed frames, swapped only between scans
module frameBuffer (
	input logic CLKDV,
	input logic reset,
	digitBus.dst in,
	frameBus.src out
);
	import numPkg::*;
	import dispPkg::*;

	typedef struct packed
	{
		digitsT digits;
		maskT blankMask;
		maskT dashMask;
	} frameT;

	frameT inFrame;                         // Frame on the converter bus
	frameT pendFrame;                       // Latest load, not yet shown
	frameT showFrame;                       // Being scanned

	assign inFrame = {in.digits, in.blankMask, in.dashMask};

	// Pending copy, newest load wins
	always_ff @(posedge CLKDV or posedge reset)
	begin
		if (reset)
			pendFrame <= {digitsT'(0), maskAll, maskNone};   // All digits dark
		else if (in.load)
			pendFrame <= inFrame;
	end

	// Displayed copy moves only at the end of digit 0
	always_ff @(posedge CLKDV or posedge reset)
	begin
		if (reset)
			showFrame <= {digitsT'(0), maskAll, maskNone};
		else if (out.frameStart)
		begin
			if (in.load)
				showFrame <= inFrame;       // Load in the same cycle goes straight through
			else
				showFrame <= pendFrame;
		end
	end

	assign out.digits = showFrame.digits;
	assign out.blankMask = showFrame.blankMask;
	assign out.dashMask = showFrame.dashMask;

endmodule : frameBuffer

`default_nettype wire

// ==== logic/ledFourDigitDriver.sv ====
`timescale 1ns/100ps
`default_nettype none

// Four-digit seven-segment driver top
module ledFourDigitDriver (
	input logic CLKDV,                      // Already divided display clock
	input logic reset,
	input logic valueStrobe,                // One cycle per new value
	input numPkg::valueT value,
	input numPkg::modeT mode,               // Decimal or hex
	output dispPkg::anodeT anodes,          // Active low
	output dispPkg::segT segments           // Active low, g down to a
);

	digitBus digBus ();                     // Converter to buffer
	frameBus frmBus ();                     // Buffer to scanner

	// Binary or hex to digits
	digitSplitter splitter0 (
		.CLKDV       (CLKDV),
		.reset       (reset),
		.valueStrobe (valueStrobe),
		.value       (value),
		.mode        (mode),
		.out         (digBus.src)
	);

	// Tear-free frame swap
	frameBuffer buffer0 (
		.CLKDV (CLKDV),
		.reset (reset),
		.in    (digBus.dst),
		.out   (frmBus.src)
	);

	// Digit scan and segment decode
	scanDriver scan0 (
		.CLKDV    (CLKDV),
		.reset    (reset),
		.frame    (frmBus.dst),
		.anodes   (anodes),
		.segments (segments)
	);

endmodule : ledFourDigitDriver

`default_nettype wire

// ==== logic/numPkg.sv ====
`default_nettype none

// Number formats shared by the converter and the display path
package numPkg;

	// Input value
	localparam int valueWidth = 16;         // Bits in one strobed value
	typedef logic [valueWidth-1:0] valueT;

	// One hex or BCD digit
	typedef logic [3:0] digitT;

	// Four digits, digit 3 in the top nibble
	typedef digitT [3:0] digitsT;

	// How the value is shown
	typedef enum logic
	{
		modeDec = 1'b0,                     // BCD with leading zero blanking
		modeHex = 1'b1                      // Raw nibbles
	} modeT;

	// Largest value that fits four decimal digits
	localparam int decLimit = 9999;

	// One shift step per input bit, same in both modes
	localparam int convCycles = valueWidth;

	// Width of the step counter, holds 0 to convCycles
	localparam int convCntWidth = $clog2(convCycles + 1);

endpackage : numPkg

`default_nettype wire

// ==== logic/scanDriver.sv ====
`timescale 1ns/100ps
`default_nettype none

// Multiplexed scan of four common-anode digits, digit 3 first
module scanDriver (
	input logic CLKDV,
	input logic reset,
	frameBus.dst frame,
	output dispPkg::anodeT anodes,
	output dispPkg::segT segments
);
	import numPkg::*;
	import dispPkg::*;

	logic [dwellWidth-1:0] dwellCnt;        // Cycles spent on this digit
	logic [digitIdxWidth-1:0] digitSel;     // Digit being lit
	logic dwellEnd;
	digitT curDigit;
	segT fontSeg;
	segT segNext;
	anodeT anodeNext;

	assign dwellEnd = (dwellCnt == dwellWidth'(dwellCycles - 1));

	// Last cycle of digit 0 closes the frame
	assign frame.frameStart = dwellEnd && (digitSel == '0);

	// Dwell and digit counters
	always_ff @(posedge CLKDV or posedge reset)
	begin
		if (reset)
		begin
			dwellCnt <= '0;
			digitSel <= digitIdxWidth'(numDigits - 1);   // Start at digit 3
		end
		else if (dwellEnd)
		begin
			dwellCnt <= '0;
			digitSel <= digitSel - 1'b1;    // 0 wraps back to 3
		end
		else
			dwellCnt <= dwellCnt + 1'b1;
	end

	assign curDigit = frame.digits[digitSel];

	// Hex font, active low, g down to a
	always_comb
	begin
		case (curDigit)
			4'h0: fontSeg = 7'b1000000;
			4'h1: fontSeg = 7'b1111001;
			4'h2: fontSeg = 7'b0100100;
			4'h3: fontSeg = 7'b0110000;
			4'h4: fontSeg = 7'b0011001;
			4'h5: fontSeg = 7'b0010010;
			4'h6: fontSeg = 7'b0000010;
			4'h7: fontSeg = 7'b1111000;
			4'h8: fontSeg = 7'b0000000;
			4'h9: fontSeg = 7'b0010000;
			4'hA: fontSeg = 7'b0001000;
			4'hB: fontSeg = 7'b0000011;  // Lower case b
			4'hC: fontSeg = 7'b1000110;
			4'hD: fontSeg = 7'b0100001;  // Lower case d
			4'hE: fontSeg = 7'b0000110;
			default: fontSeg = 7'b0001110;   // F
		endcase
	end

	// Dash over blank over font
	always_comb
	begin
		if (frame.dashMask[digitSel])
			segNext = segDash;
		else if (frame.blankMask[digitSel])
			segNext = segBlank;
		else
			segNext = fontSeg;
	end

	// One-cold select
	assign anodeNext = ~(anodeT'(1) << digitSel);

	// Outputs lag the counter by one cycle
	always_ff @(posedge CLKDV or posedge reset)
	begin
		if (reset)
		begin
			anodes <= anodesOff;            // Dark until first update
			segments <= segBlank;
		end
		else
		begin
			anodes <= anodeNext;
			segments <= segNext;
		end
	end

endmodule : scanDriver

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f tb.f \
	--top-module tbLedDriver \
	-o tbLedDriver

output=$(./obj_dir/tbLedDriver)
echo "$output"

if echo "$output" | grep -q "TB PASSED"; then
	exit 0
else
	exit 1
fi

// ==== sim/tbLedDriver.sv ====
`timescale 1ns/100ps
`default_nettype none

// Testbench for the four-digit seven-segment driver
module tbLedDriver;
	import numPkg::*;
	import dispPkg::*;

	localparam int clkPeriod = 40;          // ns
	localparam int resetCycles = 10;
	localparam int numTests = 23;           // Frames compared over the whole run
	localparam int frameCycles = numDigits * dwellCycles;
	localparam int settleCycles = convCycles + 1 + frameCycles + 2;   // Strobe to visible

	// Reference font, index is the digit code, g down to a, active low
	localparam segT refFont [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,    // 0 1 2 3
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,    // 4 5 6 7
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,    // 8 9 A b
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110     // C d E F
	};

	typedef segT [numDigits-1:0] segsT;     // One pattern per digit

	logic CLKDV;
	logic reset;
	logic valueStrobe;
	valueT value;
	modeT mode;
	anodeT anodes;
	segT segments;

	int seed = 27;
	int errCount = 0;
	int frameChecks = 0;
	int scanChecks = 0;

	// Sampler state
	segT seenSeg [numDigits];               // Last pattern seen per digit
	bit seenFlag [numDigits];
	bit seenMixed;                          // Pattern changed inside the window
	bit scanStarted = 1'b0;
	int prevIdx = -1;
	int runLen = 0;
	int lowCount;
	int litIdx;

	// Expected frame for the compare process
	segsT expSegs;
	valueT expValue;
	modeT expMode;
	event checkReq;
	event checkDone;

	ledFourDigitDriver dut0 (
		.CLKDV       (CLKDV),
		.reset       (reset),
		.valueStrobe (valueStrobe),
		.value       (value),
		.mode        (mode),
		.anodes      (anodes),
		.segments    (segments)
	);

	initial
	begin
		CLKDV = 1'b0;
		forever #(clkPeriod / 2) CLKDV = ~CLKDV;
	end

	// What the display should show for a value and mode
	function automatic segsT expectedFrame(input valueT v, input modeT m);
		segsT r;
		logic [3:0] dec [numDigits];
		int rest;
		bit leading;
		if (m == modeHex)
		begin
			for (int i = 0; i < numDigits; i++)
				r[i] = refFont[v[4*i +: 4]];          // Plain nibbles, nothing blanked
		end
		else if (int'(v) > decLimit)
			r = {numDigits{segDash}};                 // Out of range
		else
		begin
			rest = int'(v);
			for (int i = 0; i < numDigits; i++)
			begin
				dec[i] = 4'(rest % 10);
				rest = rest / 10;
			end
			leading = 1'b1;
			for (int i = numDigits - 1; i > 0; i--)
			begin
				if (leading && dec[i] == 4'd0)
					r[i] = segBlank;                  // Leading zero stays dark
				else
				begin
					leading = 1'b0;
					r[i] = refFont[dec[i]];
				end
			end
			r[0] = refFont[dec[0]];                   // Units always lit
		end
		return r;
	endfunction

	// Samples in mid-cycle, away from the rising edge
	always @(negedge CLKDV)
	begin
		if (!reset)
		begin
			lowCount = 0;
			litIdx = -1;
			for (int i = 0; i < numDigits; i++)
			begin
				if (!anodes[i])
				begin
					lowCount++;
					litIdx = i;
				end
			end
			if (scanStarted || lowCount != 0)
			begin
				scanStarted = 1'b1;                   // First registered update seen
				scanChecks++;
				if (lowCount != 1)
				begin
					errCount++;
					$display("Fail %0t: anodes %b, expected exactly one low", $time, anodes);
				end
				else
				begin
					if (seenFlag[litIdx] && seenSeg[litIdx] != segments)
						seenMixed = 1'b1;
					seenSeg[litIdx] = segments;
					seenFlag[litIdx] = 1'b1;
					// Order 3 2 1 0, four cycles each
					if (litIdx == prevIdx)
					begin
						runLen++;
						if (runLen > dwellCycles)
						begin
							errCount++;
							$display("Fail %0t: digit %0d lit for more than %0d cycles",
								$time, litIdx, dwellCycles);
						end
					end
					else
					begin
						if (prevIdx < 0 && litIdx != numDigits - 1)
						begin
							errCount++;
							$display("Fail %0t: scan started at digit %0d, expected %0d",
								$time, litIdx, numDigits - 1);
						end
						else if (prevIdx >= 0)
						begin
							if (runLen != dwellCycles)
							begin
								errCount++;
								$display("Fail %0t: digit %0d lit for %0d cycles, expected %0d",
									$time, prevIdx, runLen, dwellCycles);
							end
							if (litIdx != (prevIdx + numDigits - 1) % numDigits)
							begin
								errCount++;
								$display("Fail %0t: digit %0d followed digit %0d",
									$time, litIdx, prevIdx);
							end
						end
						prevIdx = litIdx;
						runLen = 1;
					end
				end
			end
		end
	end

	// Collects one full frame per request and compares it
	always
	begin
		@(checkReq);
		for (int i = 0; i < numDigits; i++)
			seenFlag[i] = 1'b0;
		seenMixed = 1'b0;
		repeat (frameCycles) @(posedge CLKDV);
		for (int i = 0; i < numDigits; i++)
		begin
			frameChecks++;
			if (!seenFlag[i])
			begin
				errCount++;
				$display("Digit %0d was never lit during the frame ending at %0t", i, $time);
			end
			else if (seenSeg[i] != expSegs[i])
			begin
				errCount++;
				$display("Fail %0t: digit %0d shows %b, expected %b (value %h, mode %0d)",
					$time, i, seenSeg[i], expSegs[i], expValue, expMode);
			end
		end
		if (seenMixed)
		begin
			errCount++;
			$display("A digit changed its pattern inside the frame ending at %0t", $time);
		end
		->checkDone;
	end

	// One-cycle strobe, returns on the edge after it
	task automatic strobeValue(input valueT v, input modeT m);
		@(posedge CLKDV);
		valueStrobe <= 1'b1;
		value <= v;
		mode <= m;
		@(posedge CLKDV);
		valueStrobe <= 1'b0;
	endtask

	task automatic compareFrame(input valueT v, input modeT m, input segsT segs);
		expValue = v;
		expMode = m;
		expSegs = segs;
		->checkReq;
		@(checkDone);
	endtask

	task automatic showAndCheck(input valueT v, input modeT m);
		strobeValue(v, m);
		repeat (settleCycles - 1) @(posedge CLKDV);   // Worst case latency
		compareFrame(v, m, expectedFrame(v, m));
	endtask

	// Stimulus
	initial
	begin
		reset = 1'b1;
		valueStrobe = 1'b0;
		value = '0;
		mode = modeDec;
		repeat (resetCycles) @(posedge CLKDV);
		reset <= 1'b0;
		repeat (2) @(posedge CLKDV);

		// Nothing loaded yet, all dark
		compareFrame('0, modeDec, {numDigits{segBlank}});

		// Decimal
		showAndCheck(16'd0, modeDec);
		showAndCheck(16'd7, modeDec);
		showAndCheck(16'd40, modeDec);
		showAndCheck(16'd305, modeDec);
		showAndCheck(16'd9999, modeDec);
		showAndCheck(16'd1000, modeDec);
		showAndCheck(16'd1234, modeDec);

		// Above the decimal range
		showAndCheck(16'd10000, modeDec);
		showAndCheck(16'd65535, modeDec);

		// Hexadecimal
		showAndCheck(16'h0000, modeHex);
		showAndCheck(16'hBEEF, modeHex);
		repeat (6) showAndCheck(valueT'($random(seed)), modeHex);
		repeat (4) showAndCheck(valueT'($random(seed)), modeDec);   // Some land above 9999

		// Second strobe restarts the conversion
		strobeValue(16'd4321, modeDec);
		repeat (3) @(posedge CLKDV);
		showAndCheck(16'hA5F0, modeHex);

		$display("Frame checks: %0d, scan cycles checked: %0d, errors: %0d",
			frameChecks, scanChecks, errCount);
		if (errCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (resetCycles + numTests * 60) @(posedge CLKDV);
		$display("Timeout: the tests did not finish within %0d cycles",
			resetCycles + numTests * 60);
		$display("TB FAILED");
		$finish;
	end

endmodule : tbLedDriver

`default_nettype wire

// ==== tb.f ====
logic/numPkg.sv
logic/dispPkg.sv
logic/displayBuses.sv
logic/digitSplitter.sv
logic/frameBuffer.sv
logic/scanDriver.sv
logic/ledFourDigitDriver.sv
sim/tbLedDriver.sv
